// ==== hw/edge_stats_pkg.sv ====
`default_nettype none

package edge_stats_pkg;

	// Colour channel width is fixed by the video format
	localparam int CHAN_W = 8;

	localparam int NUM_EDGES = 4;
	localparam int NUM_CHAN = 3;

	// Channel index inside one edge
	localparam int CH_R = 0;
	localparam int CH_G = 1;
	localparam int CH_B = 2;

	typedef enum logic [1:0]
	{
		TOP = 2'd0,
		BOTTOM = 2'd1,
		LEFT = 2'd2,
		RIGHT = 2'd3
	} edge_e;

	// Result of one channel of one edge, max in the low byte
	typedef struct packed
	{
		logic done;
		logic [6:0] zero;
		logic [CHAN_W-1:0] avg;
		logic [CHAN_W-1:0] min;
		logic [CHAN_W-1:0] max;
	} edge_stat_s;

	typedef union packed
	{
		logic [31:0] raw;
		edge_stat_s f;
	} edge_stat_u;

	// Wishbone word addresses
	localparam logic [3:0] ANCHOR_ADR = 4'd0;
	localparam logic [3:0] STAT_BASE_ADR = 4'd1;

	// Anchor y position inside the anchor word
	localparam int ANCHOR_Y_LSB = 16;

endpackage

`default_nettype wire

// ==== hw/pixel_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// One classified background pixel
interface pixel_if
	import edge_stats_pkg::*;
();

	logic valid;
	logic sof;
	logic [NUM_EDGES-1:0] edge_mask;
	logic [CHAN_W-1:0] r;
	logic [CHAN_W-1:0] g;
	logic [CHAN_W-1:0] b;

	modport src
	(
		output valid, sof, edge_mask, r, g, b
	);

	modport dst
	(
		input valid, sof, edge_mask, r, g, b
	);

endinterface

`default_nettype wire

// ==== hw/sprite_box_classifier.sv ====
`timescale 1ns/1ps
`default_nettype none

module sprite_box_classifier
	import edge_stats_pkg::*;
#(
	parameter int SPRITE_SIZE = 16,
	parameter int COORD_W = 10
)
(
	input wire clk,
	input wire rst,
	input wire pix_valid,
	input wire pix_sof,
	input wire [COORD_W-1:0] pix_x,
	input wire [COORD_W-1:0] pix_y,
	input wire [CHAN_W-1:0] pix_r,
	input wire [CHAN_W-1:0] pix_g,
	input wire [CHAN_W-1:0] pix_b,
	input wire [COORD_W-1:0] anchor_x,
	input wire [COORD_W-1:0] anchor_y,
	pixel_if.src pix
);

	localparam logic [COORD_W:0] SIDE = (COORD_W+1)'(SPRITE_SIZE);
	localparam logic [COORD_W:0] LAST = (COORD_W+1)'(SPRITE_SIZE - 1);

	logic take_anchor;
	logic [COORD_W-1:0] anchor_x_q;
	logic [COORD_W-1:0] anchor_y_q;
	logic [COORD_W-1:0] cur_x;
	logic [COORD_W-1:0] cur_y;
	logic [COORD_W:0] off_x;
	logic [COORD_W:0] off_y;
	logic in_x;
	logic in_y;
	logic [NUM_EDGES-1:0] mask_c;

	assign take_anchor = pix_valid && pix_sof;

	// The sof pixel already sees the new anchor
	assign cur_x = take_anchor ? anchor_x : anchor_x_q;
	assign cur_y = take_anchor ? anchor_y : anchor_y_q;

	// One extra bit so that left of or above the anchor wraps to a large offset
	assign off_x = {1'b0, pix_x} - {1'b0, cur_x};
	assign off_y = {1'b0, pix_y} - {1'b0, cur_y};
	assign in_x = off_x < SIDE;
	assign in_y = off_y < SIDE;

	always_comb
	begin
		mask_c = '0;
		if (pix_valid)
		begin
			mask_c[TOP] = in_x && (off_y == '0);
			mask_c[BOTTOM] = in_x && (off_y == LAST);
			mask_c[LEFT] = in_y && (off_x == '0);
			mask_c[RIGHT] = in_y && (off_x == LAST);
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			anchor_x_q <= '0;
			anchor_y_q <= '0;
		end
		else if (take_anchor)
		begin
			anchor_x_q <= anchor_x;
			anchor_y_q <= anchor_y;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			pix.valid <= 1'b0;
			pix.sof <= 1'b0;
			pix.edge_mask <= '0;
		end
		else
		begin
			pix.valid <= pix_valid;
			pix.sof <= take_anchor;
			pix.edge_mask <= mask_c;
		end
	end

	always_ff @(posedge clk)
	begin
		pix.r <= pix_r;
		pix.g <= pix_g;
		pix.b <= pix_b;
	end

	// Accumulators count any set mask bit, so idle cycles must carry none
	mask_idle: assert property (@(posedge clk) disable iff (rst)
		!pix.valid |-> (pix.edge_mask == '0));

endmodule

`default_nettype wire

// ==== hw/edge_accumulator.sv ====
`timescale 1ns/1ps
`default_nettype none

module edge_accumulator
	import edge_stats_pkg::*;
#(
	parameter int SPRITE_SIZE = 16,
	parameter edge_e EDGE = TOP
)
(
	input wire clk,
	input wire rst,
	pixel_if.dst pix,
	output edge_stat_u stats [NUM_CHAN]
);

	localparam int SHIFT = $clog2(SPRITE_SIZE);
	localparam int SUM_W = CHAN_W + SHIFT;
	localparam int CNT_W = SHIFT + 1;
	localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(SPRITE_SIZE);

	logic restart;
	logic hit;
	logic [CHAN_W-1:0] chan [NUM_CHAN];
	logic [CNT_W-1:0] cnt_q;
	logic [CNT_W-1:0] cnt_n;
	logic [SUM_W-1:0] sum_q [NUM_CHAN];
	logic [SUM_W-1:0] sum_n [NUM_CHAN];
	edge_stat_u stat_q [NUM_CHAN];
	edge_stat_u stat_n [NUM_CHAN];

	assign restart = pix.valid && pix.sof;
	assign hit = pix.valid && pix.edge_mask[EDGE];

	assign chan[CH_R] = pix.r;
	assign chan[CH_G] = pix.g;
	assign chan[CH_B] = pix.b;

	always_comb
	begin
		cnt_n = cnt_q;
		if (restart)
			cnt_n = hit ? CNT_W'(1) : '0;
		else if (hit && cnt_q != CNT_FULL)
			cnt_n = cnt_q + 1'b1;
	end

	always_comb
	begin
		for (int c = 0; c < NUM_CHAN; c++)
		begin
			stat_n[c].raw = '0;
			stat_n[c].f.max = stat_q[c].f.max;
			stat_n[c].f.min = stat_q[c].f.min;
			sum_n[c] = sum_q[c];

			if (restart)
			begin
				// Start of frame seeds from this pixel or from empty
				if (hit)
				begin
					stat_n[c].f.max = chan[c];
					stat_n[c].f.min = chan[c];
					sum_n[c] = SUM_W'(chan[c]);
				end
				else
				begin
					stat_n[c].f.max = '0;
					stat_n[c].f.min = '1;
					sum_n[c] = '0;
				end
			end
			else if (hit)
			begin
				if (chan[c] > stat_q[c].f.max)
					stat_n[c].f.max = chan[c];
				if (chan[c] < stat_q[c].f.min)
					stat_n[c].f.min = chan[c];
				sum_n[c] = sum_q[c] + SUM_W'(chan[c]);
			end

			// Divide by the box side
			stat_n[c].f.avg = sum_n[c][SUM_W-1:SHIFT];
			stat_n[c].f.done = (cnt_n == CNT_FULL);
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			cnt_q <= '0;
			for (int c = 0; c < NUM_CHAN; c++)
			begin
				sum_q[c] <= '0;
				stat_q[c].raw <= '0;
			end
		end
		else
		begin
			cnt_q <= cnt_n;
			for (int c = 0; c < NUM_CHAN; c++)
			begin
				sum_q[c] <= sum_n[c];
				stat_q[c] <= stat_n[c];
			end
		end
	end

	assign stats = stat_q;

	// One frame never puts more than SPRITE_SIZE pixels on an edge
	cnt_bound: assert property (@(posedge clk) disable iff (rst)
		(hit && !restart) |-> (cnt_q < CNT_FULL));

endmodule

`default_nettype wire

// ==== hw/wb_stat_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_stat_regs
	import edge_stats_pkg::*;
#(
	parameter int COORD_W = 10
)
(
	input wire clk,
	input wire rst,
	input wire wb_cyc,
	input wire wb_stb,
	input wire wb_we,
	input wire [3:0] wb_adr,
	input wire [31:0] wb_dat_w,
	output logic [31:0] wb_dat_r,
	output logic wb_ack,
	output logic [COORD_W-1:0] anchor_x,
	output logic [COORD_W-1:0] anchor_y,
	input wire edge_stat_u stats [NUM_EDGES][NUM_CHAN]
);

	logic req;
	logic first;
	logic [31:0] rd_word;

	assign req = wb_cyc && wb_stb;

	// First cycle of a request, before the ack goes out
	assign first = req && !wb_ack;

	always_comb
	begin
		rd_word = '0;
		if (wb_adr == ANCHOR_ADR)
		begin
			rd_word[COORD_W-1:0] = anchor_x;
			rd_word[ANCHOR_Y_LSB +: COORD_W] = anchor_y;
		end
		for (int e = 0; e < NUM_EDGES; e++)
		begin
			for (int c = 0; c < NUM_CHAN; c++)
			begin
				if (wb_adr == STAT_BASE_ADR + 4'(NUM_CHAN * e + c))
					rd_word = stats[e][c].raw;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wb_ack <= 1'b0;
			anchor_x <= '0;
			anchor_y <= '0;
		end
		else
		begin
			wb_ack <= first;
			// Only the anchor word is writable
			if (first && wb_we && wb_adr == ANCHOR_ADR)
			begin
				anchor_x <= wb_dat_w[COORD_W-1:0];
				anchor_y <= wb_dat_w[ANCHOR_Y_LSB +: COORD_W];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (first)
			wb_dat_r <= rd_word;
	end

	ack_needs_req: assert property (@(posedge clk) disable iff (rst)
		wb_ack |-> $past(wb_cyc && wb_stb));

	ack_single: assert property (@(posedge clk) disable iff (rst)
		wb_ack |=> !wb_ack);

endmodule

`default_nettype wire

// ==== hw/sprite_edge_stats.sv ====
`timescale 1ns/1ps
`default_nettype none

module sprite_edge_stats
	import edge_stats_pkg::*;
#(
	parameter int SPRITE_SIZE = 16,
	parameter int COORD_W = 10
)
(
	input wire clk,
	input wire rst,

	// Background pixel stream
	input wire pix_valid,
	input wire pix_sof,
	input wire [COORD_W-1:0] pix_x,
	input wire [COORD_W-1:0] pix_y,
	input wire [CHAN_W-1:0] pix_r,
	input wire [CHAN_W-1:0] pix_g,
	input wire [CHAN_W-1:0] pix_b,

	// Wishbone classic slave
	input wire wb_cyc,
	input wire wb_stb,
	input wire wb_we,
	input wire [3:0] wb_adr,
	input wire [31:0] wb_dat_w,
	output logic [31:0] wb_dat_r,
	output logic wb_ack
);

	logic [COORD_W-1:0] anchor_x;
	logic [COORD_W-1:0] anchor_y;
	edge_stat_u stats [NUM_EDGES][NUM_CHAN];

	pixel_if pix_bus ();

	sprite_box_classifier #(
		.SPRITE_SIZE(SPRITE_SIZE),
		.COORD_W(COORD_W)
	) u_classifier (
		.clk(clk),
		.rst(rst),
		.pix_valid(pix_valid),
		.pix_sof(pix_sof),
		.pix_x(pix_x),
		.pix_y(pix_y),
		.pix_r(pix_r),
		.pix_g(pix_g),
		.pix_b(pix_b),
		.anchor_x(anchor_x),
		.anchor_y(anchor_y),
		.pix(pix_bus.src)
	);

	// One accumulator per edge
	for (genvar e = 0; e < NUM_EDGES; e++)
	begin : g_edge
		edge_accumulator #(
			.SPRITE_SIZE(SPRITE_SIZE),
			.EDGE(edge_e'(e))
		) u_acc (
			.clk(clk),
			.rst(rst),
			.pix(pix_bus.dst),
			.stats(stats[e])
		);
	end

	wb_stat_regs #(
		.COORD_W(COORD_W)
	) u_regs (
		.clk(clk),
		.rst(rst),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack),
		.anchor_x(anchor_x),
		.anchor_y(anchor_y),
		.stats(stats)
	);

endmodule

`default_nettype wire

// ==== bench/tb_sprite_edge_stats.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_sprite_edge_stats;

	localparam int SIDE = 16;
	localparam int LOG_SIDE = 4;
	localparam int FRAME_W = 48;
	localparam int FRAME_H = 40;
	localparam int WB_TIMEOUT = 20;

	logic clk;
	logic rst;
	logic pix_valid;
	logic pix_sof;
	logic [9:0] pix_x;
	logic [9:0] pix_y;
	logic [7:0] pix_r;
	logic [7:0] pix_g;
	logic [7:0] pix_b;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [3:0] wb_adr;
	logic [31:0] wb_dat_w;
	wire [31:0] wb_dat_r;
	wire wb_ack;

	int checks;
	int errors;
	int test_errors;
	logic [31:0] anchor_reg;

	// Reference statistics, edge order top, bottom, left, right
	int m_max [4][3];
	int m_min [4][3];
	int m_sum [4][3];
	int m_cnt [4];

	sprite_edge_stats DUT (.*);

	always #4 clk = ~clk;

	task automatic report_error(input string msg);
		errors++;
		$display("CHECK FAILED at %0t: %s", $time, msg);
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Test failed");
		$finish;
	endtask

	task automatic check_word(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp)
		else
			report_error($sformatf("%s read %h, expected %h", what, got, exp));
	endtask

	// Each ack must follow a request that was pending on the previous edge
	ack_after_req: assert property (@(posedge clk) disable iff (rst)
		wb_ack |-> $past(wb_cyc && wb_stb && !wb_ack))
	else
		report_error("ack without a pending request");

	task automatic bus_cycle(input logic we, input logic [3:0] adr, input logic [31:0] wdat,
		output logic [31:0] rdat);
		int waited;
		waited = 0;
		rdat = '0;
		checks++;
		assert (!wb_ack)
		else
			report_error("ack already high when the request starts");
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_dat_w = wdat;
		do
		begin
			@(negedge clk);
			waited++;
		end
		while (!wb_ack && waited < WB_TIMEOUT);
		if (!wb_ack)
			abort_run($sformatf("Wishbone slave gave no ack for address %0d", adr));
		else
		begin
			rdat = wb_dat_r;
			wb_cyc = 1'b0;
			wb_stb = 1'b0;
			wb_we = 1'b0;
			@(negedge clk);
			checks++;
			assert (!wb_ack)
			else
				report_error("ack held for more than one cycle");
		end
	endtask

	task automatic read_word(input logic [3:0] adr, output logic [31:0] data);
		bus_cycle(1'b0, adr, 32'h0, data);
	endtask

	task automatic write_word(input logic [3:0] adr, input logic [31:0] data);
		logic [31:0] ignored;
		bus_cycle(1'b1, adr, data, ignored);
	endtask

	task automatic set_anchor(input int x, input int y);
		anchor_reg = {6'b0, 10'(y), 6'b0, 10'(x)};
		write_word(4'd0, anchor_reg);
	endtask

	task automatic model_clear(input int min_start);
		for (int e = 0; e < 4; e++)
		begin
			m_cnt[e] = 0;
			for (int c = 0; c < 3; c++)
			begin
				m_max[e][c] = 0;
				m_min[e][c] = min_start;
				m_sum[e][c] = 0;
			end
		end
	endtask

	task automatic model_pixel(input int x, input int y, input int ax, input int ay,
		input logic [7:0] r, input logic [7:0] g, input logic [7:0] b);
		bit [3:0] on_edge;
		bit in_x;
		bit in_y;
		int val [3];
		in_x = (x >= ax) && (x < ax + SIDE);
		in_y = (y >= ay) && (y < ay + SIDE);
		// Corners land on two edges
		on_edge[0] = in_x && (y == ay);
		on_edge[1] = in_x && (y == ay + SIDE - 1);
		on_edge[2] = in_y && (x == ax);
		on_edge[3] = in_y && (x == ax + SIDE - 1);
		val[0] = r;
		val[1] = g;
		val[2] = b;
		for (int e = 0; e < 4; e++)
		begin
			if (on_edge[e])
			begin
				m_cnt[e]++;
				for (int c = 0; c < 3; c++)
				begin
					if (val[c] > m_max[e][c])
						m_max[e][c] = val[c];
					if (val[c] < m_min[e][c])
						m_min[e][c] = val[c];
					m_sum[e][c] += val[c];
				end
			end
		end
	endtask

	function automatic logic [31:0] expected_word(input int e, input int c);
		logic [7:0] avg;
		logic done;
		avg = 8'(m_sum[e][c] >> LOG_SIDE);
		done = (m_cnt[e] == SIDE);
		return {done, 7'b0, avg, 8'(m_min[e][c]), 8'(m_max[e][c])};
	endfunction

	task automatic check_stats(input string tag);
		logic [31:0] data;
		for (int e = 0; e < 4; e++)
		begin
			for (int c = 0; c < 3; c++)
			begin
				read_word(4'(1 + 3 * e + c), data);
				check_word($sformatf("%s edge %0d chan %0d", tag, e, c), data,
					expected_word(e, c));
			end
		end
	endtask

	// Raster frame with random colours, optional anchor write at pixel change_at
	task automatic send_frame(input int change_at, input int new_x, input int new_y);
		int idx;
		int ax;
		int ay;
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
		idx = 0;
		ax = int'(anchor_reg[9:0]);
		ay = int'(anchor_reg[25:16]);
		model_clear(255);
		for (int y = 0; y < FRAME_H; y++)
		begin
			for (int x = 0; x < FRAME_W; x++)
			begin
				pix_valid = 1'b0;
				pix_sof = 1'b0;
				if (idx == change_at)
					set_anchor(new_x, new_y);
				if ($urandom_range(0, 7) == 0)
					repeat ($urandom_range(1, 3)) @(negedge clk);
				r = 8'($urandom);
				g = 8'($urandom);
				b = 8'($urandom);
				pix_valid = 1'b1;
				pix_sof = (idx == 0);
				pix_x = 10'(x);
				pix_y = 10'(y);
				pix_r = r;
				pix_g = g;
				pix_b = b;
				model_pixel(x, y, ax, ay, r, g, b);
				@(negedge clk);
				idx++;
			end
		end
		pix_valid = 1'b0;
		pix_sof = 1'b0;
		// Two cycles of pipeline before the read-out
		repeat (3) @(negedge clk);
	endtask

	task automatic finish_test(input string name);
		$display("%s finished with %0d errors", name, errors - test_errors);
		test_errors = errors;
	endtask

	initial
	begin
		logic [31:0] data;
		logic [3:0] adr;
		void'($urandom(32'h2298_7736));
		clk = 1'b0;
		rst = 1'b1;
		pix_valid = 1'b0;
		pix_sof = 1'b0;
		pix_x = '0;
		pix_y = '0;
		pix_r = '0;
		pix_g = '0;
		pix_b = '0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		checks = 0;
		errors = 0;
		test_errors = 0;
		anchor_reg = '0;
		repeat (8) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);

		model_clear(0);
		check_stats("reset");
		read_word(4'd0, data);
		check_word("anchor after reset", data, 32'h0);
		finish_test("after_reset");

		set_anchor(682, 341);
		read_word(4'd0, data);
		check_word("anchor readback", data, anchor_reg);
		write_word(4'd5, 32'hFFFF_FFFF);
		read_word(4'd5, data);
		check_word("read-only word", data, expected_word(1, 1));
		finish_test("anchor_register");

		set_anchor(10, 7);
		send_frame(-1, 0, 0);
		check_stats("full frame");
		finish_test("full_frame");

		set_anchor(40, 30);
		send_frame(-1, 0, 0);
		check_stats("clipped box");
		finish_test("clipped_box");

		set_anchor(10, 7);
		send_frame(800, 20, 12);
		check_stats("old anchor frame");
		send_frame(-1, 0, 0);
		check_stats("new anchor frame");
		finish_test("anchor_change");

		// Every address, unmapped ones read as zero
		for (int i = 0; i < 16; i++)
		begin
			adr = 4'(i);
			read_word(adr, data);
			if (adr == 4'd0)
				check_word("anchor", data, anchor_reg);
			else if (adr <= 4'd12)
				check_word($sformatf("word %0d", adr), data,
					expected_word((adr - 1) / 3, (adr - 1) % 3));
			else
				check_word($sformatf("unmapped word %0d", adr), data, 32'h0);
		end
		finish_test("single_ack");

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
hw/edge_stats_pkg.sv
hw/pixel_if.sv
hw/sprite_box_classifier.sv
hw/edge_accumulator.sv
hw/wb_stat_regs.sv
hw/sprite_edge_stats.sv
bench/tb_sprite_edge_stats.sv
